// ==== files.f ====
rtl/ctrlport_pkg.sv
rtl/ctrlport_flop_fifo.sv
rtl/timebase_counter.sv
rtl/ctrlport_timer.sv
rtl/ctrlport_reg_file.sv
rtl/ctrlport_timed_regs_top.sv
verification/tb_ctrlport_timed_regs.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the timed register testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

TOP=tb_ctrlport_timed_regs
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module "${TOP}" \
  -Mdir obj_dir \
  -f files.f

./obj_dir/V${TOP} | tee "${LOG}"

if grep -qx "Result: PASSED" "${LOG}"; then
  echo "Simulation passed"
else
  echo "Simulation failed, see ${LOG}"
  exit 1
fi

// ==== verification/tb_ctrlport_timed_regs.sv ====
`timescale 1ns/100ps

module tb_ctrlport_timed_regs;
  import ctrlport_pkg::*;

  localparam bit EXEC_LATE_CMDS = 1'b0;
  localparam int TICK_DIV       = 4;
  localparam int NUM_REGS       = 8;
  // Requests over all six tests, read-backs included
  localparam int NUM_REQS       = 24 + 20 + 8 + 8 + 14 + 4;
  // Largest distance in ticks between a timed request and the timebase
  localparam int MAX_OFFSET     = 5;
  // Drive, pipeline and response, plus waiting out the offset
  localparam int ACK_WAIT       = 12 + (MAX_OFFSET + 1) * TICK_DIV;
  localparam int CYCLE_LIMIT    = NUM_REQS * ACK_WAIT + 100;

  logic                   clk;
  logic                   arst_n;
  logic [3:0]             time_ignore_bits;
  logic                   req_wr;
  logic                   req_rd;
  logic [CTRL_ADDR_W-1:0] req_addr;
  logic [CTRL_DATA_W-1:0] req_data;
  logic [CTRL_BE_W-1:0]   req_byte_en;
  logic                   req_has_time;
  logic [TIME_W-1:0]      req_time;
  logic                   resp_ack;
  ctrl_status_e           resp_status;
  logic [CTRL_DATA_W-1:0] resp_data;
  logic [TIME_W-1:0]      time_now;

  // Reference register bank and the expectation for the outstanding request
  logic [CTRL_DATA_W-1:0] model_regs [NUM_REGS];
  ctrl_status_e           exp_status;
  logic [CTRL_DATA_W-1:0] exp_data;
  logic                   exp_timed;
  logic [TIME_W-1:0]      exp_time;
  int                     req_cycle;
  logic [15:0]            lfsr;

  // Counters, each written by one process only
  int cycle_cnt    = 0;
  int issued_cnt   = 0;
  int acked_cnt    = 0;
  int chk_cnt      = 0;
  int mon_err_cnt  = 0;
  int stim_err_cnt = 0;
  int test_num     = 0;
  int err_base     = 0;
  int req_base     = 0;

  ctrlport_timed_regs_top #(
    .EXEC_LATE_CMDS(EXEC_LATE_CMDS),
    .TICK_DIV      (TICK_DIV),
    .NUM_REGS      (NUM_REGS)
  ) u_dut (
    .clk               (clk),
    .i_arst_n          (arst_n),
    .i_time_ignore_bits(time_ignore_bits),
    .i_req_wr          (req_wr),
    .i_req_rd          (req_rd),
    .i_req_addr        (req_addr),
    .i_req_data        (req_data),
    .i_req_byte_en     (req_byte_en),
    .i_req_has_time    (req_has_time),
    .i_req_time        (req_time),
    .o_resp_ack        (resp_ack),
    .o_resp_status     (resp_status),
    .o_resp_data       (resp_data),
    .o_time_now        (time_now)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [CTRL_ADDR_W-1:0] reg_addr(input int idx);
    return CTRL_ADDR_W'(idx * 4);
  endfunction

  function automatic logic [TIME_W-1:0] time_mask(input logic [3:0] ign);
    return ~(TIME_W'(0)) << ign;
  endfunction

  // Expected status and data, and the model update for a write
  function automatic void predict(input logic wr, input logic [CTRL_ADDR_W-1:0] addr,
                                  input logic [CTRL_DATA_W-1:0] data,
                                  input logic [CTRL_BE_W-1:0] be, input logic has_time,
                                  input logic [TIME_W-1:0] t, input logic [TIME_W-1:0] now,
                                  output ctrl_status_e sts,
                                  output logic [CTRL_DATA_W-1:0] rdata);
    logic [TIME_W-1:0] mask;
    logic              late;
    int                idx;
    mask  = time_mask(time_ignore_bits);
    idx   = int'(addr[CTRL_ADDR_W-1:2]);
    // The first strobe seen after the request carries now + 1
    late  = has_time && ((t & mask) < ((now + TIME_W'(1)) & mask));
    rdata = '0;
    if (late && !EXEC_LATE_CMDS) begin
      sts = STS_TSERR;
    end else if (addr[1:0] != 2'b00 || idx >= NUM_REGS) begin
      sts = STS_CMDERR;
    end else begin
      sts = STS_OKAY;
      if (wr) begin
        for (int b = 0; b < CTRL_BE_W; b++) begin
          if (be[b]) begin
            model_regs[idx][8*b +: 8] = data[8*b +: 8];
          end
        end
      end else begin
        rdata = model_regs[idx];
      end
    end
  endfunction

  task automatic check_status(input string name, input ctrl_status_e got,
                              input ctrl_status_e exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
      mon_err_cnt++;
    end
  endtask

  task automatic check_data(input string name, input logic [CTRL_DATA_W-1:0] got,
                            input logic [CTRL_DATA_W-1:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
      mon_err_cnt++;
    end
  endtask

  // Response monitor, outputs are stable at the falling edge
  always @(negedge clk) begin
    if (arst_n && resp_ack === 1'b1) begin
      if (acked_cnt == issued_cnt) begin
        $display("Acknowledge arrived with no request outstanding");
        mon_err_cnt++;
      end else begin
        check_status("o_resp_status", resp_status, exp_status);
        check_data("o_resp_data", resp_data, exp_data);
        if (!exp_timed && cycle_cnt - req_cycle != 6) begin
          $display("Untimed request acknowledged after %0d cycles instead of 6",
                   cycle_cnt - req_cycle);
          mon_err_cnt++;
        end
        // Executed timed requests must not run ahead of the timebase
        if (exp_timed && exp_status == STS_OKAY &&
            (time_now & time_mask(time_ignore_bits)) <
            (exp_time & time_mask(time_ignore_bits))) begin
          $display("Timed request ran early at time 0x%016h, requested 0x%016h",
                   time_now, exp_time);
          mon_err_cnt++;
        end
        acked_cnt++;
      end
    end
  end

  // One request pulse, time relative to the timebase at the drive edge
  task automatic issue(input logic wr, input logic [CTRL_ADDR_W-1:0] addr,
                       input logic [CTRL_DATA_W-1:0] data, input logic [CTRL_BE_W-1:0] be,
                       input logic has_time, input longint offset);
    logic [TIME_W-1:0] t;
    int                waited;
    @(negedge clk);
    t = time_now + TIME_W'(offset);
    predict(wr, addr, data, be, has_time, t, time_now, exp_status, exp_data);
    exp_timed    = has_time;
    exp_time     = t;
    req_cycle    = cycle_cnt;
    issued_cnt++;
    req_wr       = wr;
    req_rd       = !wr;
    req_addr     = addr;
    req_data     = data;
    req_byte_en  = be;
    req_has_time = has_time;
    req_time     = t;
    @(negedge clk);
    req_wr       = 1'b0;
    req_rd       = 1'b0;
    req_has_time = 1'b0;
    waited       = 1;
    while (resp_ack !== 1'b1 && waited < ACK_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (resp_ack !== 1'b1) begin
      $display("No acknowledge within %0d cycles for request to 0x%05h", ACK_WAIT, addr);
      stim_err_cnt++;
    end
  endtask

  task automatic read_all();
    for (int i = 0; i < NUM_REGS; i++) begin
      issue(1'b0, reg_addr(i), '0, '0, 1'b0, 0);
    end
  endtask

  // Lets the monitor finish the last acknowledge before counting
  task automatic finish_test(input string name);
    int errs;
    @(negedge clk);
    test_num++;
    errs = stim_err_cnt + mon_err_cnt - err_base;
    $display("Test %0d %s: %0d requests, %0d errors", test_num, name,
             issued_cnt - req_base, errs);
    err_base = stim_err_cnt + mon_err_cnt;
    req_base = issued_cnt;
  endtask

  initial begin
    logic [CTRL_ADDR_W-1:0] addr;
    longint                 offset;
    int                     idx;
    int                     total;
    arst_n           = 1'b0;
    time_ignore_bits = 4'd0;
    req_wr           = 1'b0;
    req_rd           = 1'b0;
    req_addr         = '0;
    req_data         = '0;
    req_byte_en      = '0;
    req_has_time     = 1'b0;
    req_time         = '0;
    lfsr             = 16'd14427;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    repeat (3) @(negedge clk);
    arst_n = 1'b1;

    // Full-word writes to random registers
    for (int i = 0; i < 16; i++) begin
      idx = int'(take_bits(3));
      issue(1'b1, reg_addr(idx), take_bits(32), 4'hF, 1'b0, 0);
    end
    read_all();
    finish_test("untimed random writes");

    for (int i = 0; i < 12; i++) begin
      idx = int'(take_bits(3));
      issue(1'b1, reg_addr(idx), take_bits(32), CTRL_BE_W'(take_bits(CTRL_BE_W)), 1'b0, 0);
    end
    read_all();
    finish_test("byte-enable writes");

    // A few ticks ahead, held until the timebase gets there
    for (int i = 0; i < 4; i++) begin
      idx    = int'(take_bits(3));
      offset = 2 + longint'(take_bits(2));
      issue(1'b1, reg_addr(idx), take_bits(32), 4'hF, 1'b1, offset);
      issue(1'b0, reg_addr(idx), '0, '0, 1'b0, 0);
    end
    finish_test("timed writes ahead");

    // Already in the past, dropped
    for (int i = 0; i < 4; i++) begin
      idx    = int'(take_bits(3));
      offset = -(1 + longint'(take_bits(2)));
      issue(1'b1, reg_addr(idx), take_bits(32), 4'hF, 1'b1, offset);
      issue(1'b0, reg_addr(idx), '0, '0, 1'b0, 0);
    end
    finish_test("late timed writes");

    // Past the bank, misaligned, and far out of range
    for (int i = 0; i < 6; i++) begin
      case (i)
        0: addr = reg_addr(NUM_REGS);
        1: addr = reg_addr(NUM_REGS + int'(take_bits(4)));
        2: addr = reg_addr(int'(take_bits(3))) | CTRL_ADDR_W'(1);
        3: addr = reg_addr(int'(take_bits(3))) | CTRL_ADDR_W'(2);
        4: addr = reg_addr(int'(take_bits(3))) | CTRL_ADDR_W'(3);
        default: addr = CTRL_ADDR_W'(take_bits(CTRL_ADDR_W)) | CTRL_ADDR_W'('h80000);
      endcase
      issue(i % 2 == 0, addr, take_bits(32), 4'hF, 1'b0, 0);
    end
    read_all();
    finish_test("unmapped addresses");

    // Request one tick behind, but in the same 4-tick window
    time_ignore_bits = 4'd2;
    for (int i = 0; i < 2; i++) begin
      while (time_now[1:0] != 2'b01) begin
        @(negedge clk);
      end
      idx = int'(take_bits(3));
      issue(1'b1, reg_addr(idx), take_bits(32), 4'hF, 1'b1, -1);
      issue(1'b0, reg_addr(idx), '0, '0, 1'b0, 0);
    end
    finish_test("masked time compare");

    total = stim_err_cnt + mon_err_cnt;
    $display("Summary: %0d tests, %0d requests, %0d checks, %0d errors",
             test_num, issued_cnt, chk_cnt, total);
    if (total == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Run limit from request count and worst wait per request
  initial begin
    wait (cycle_cnt >= CYCLE_LIMIT);
    $display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== rtl/ctrlport_timed_regs_top.sv ====
`timescale 1ns/100ps

module ctrlport_timed_regs_top #(
  parameter bit EXEC_LATE_CMDS = 1'b0,
  parameter int TICK_DIV       = 4,
  parameter int NUM_REGS       = 8
) (
  input  logic                                 clk,
  input  logic                                 i_arst_n,
  input  logic [3:0]                           i_time_ignore_bits,
  input  logic                                 i_req_wr,
  input  logic                                 i_req_rd,
  input  logic [ctrlport_pkg::CTRL_ADDR_W-1:0] i_req_addr,
  input  logic [ctrlport_pkg::CTRL_DATA_W-1:0] i_req_data,
  input  logic [ctrlport_pkg::CTRL_BE_W-1:0]   i_req_byte_en,
  input  logic                                 i_req_has_time,
  input  logic [ctrlport_pkg::TIME_W-1:0]      i_req_time,
  output logic                                 o_resp_ack,
  output ctrlport_pkg::ctrl_status_e           o_resp_status,
  output logic [ctrlport_pkg::CTRL_DATA_W-1:0] o_resp_data,
  output logic [ctrlport_pkg::TIME_W-1:0]      o_time_now
);
  import ctrlport_pkg::*;

  // Timebase strobe into the timer
  logic                   time_stb;

  // Timer to register file
  logic                   reg_req_wr;
  logic                   reg_req_rd;
  logic [CTRL_ADDR_W-1:0] reg_req_addr;
  logic [CTRL_DATA_W-1:0] reg_req_data;
  logic [CTRL_BE_W-1:0]   reg_req_byte_en;
  logic                   reg_resp_ack;
  ctrl_status_e           reg_resp_status;
  logic [CTRL_DATA_W-1:0] reg_resp_data;

  timebase_counter #(.TICK_DIV(TICK_DIV)) u_timebase (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .o_time_now(o_time_now),
    .o_time_stb(time_stb)
  );

  // Shares the exported time with the host
  ctrlport_timer #(.EXEC_LATE_CMDS(EXEC_LATE_CMDS)) u_timer (
    .clk               (clk),
    .i_arst_n          (i_arst_n),
    .i_time_now        (o_time_now),
    .i_time_stb        (time_stb),
    .i_time_ignore_bits(i_time_ignore_bits),
    .s_req_wr          (i_req_wr),
    .s_req_rd          (i_req_rd),
    .s_req_addr        (i_req_addr),
    .s_req_data        (i_req_data),
    .s_req_byte_en     (i_req_byte_en),
    .s_req_has_time    (i_req_has_time),
    .s_req_time        (i_req_time),
    .s_resp_ack        (o_resp_ack),
    .s_resp_status     (o_resp_status),
    .s_resp_data       (o_resp_data),
    .m_req_wr          (reg_req_wr),
    .m_req_rd          (reg_req_rd),
    .m_req_addr        (reg_req_addr),
    .m_req_data        (reg_req_data),
    .m_req_byte_en     (reg_req_byte_en),
    .m_resp_ack        (reg_resp_ack),
    .m_resp_status     (reg_resp_status),
    .m_resp_data       (reg_resp_data)
  );

  ctrlport_reg_file #(.NUM_REGS(NUM_REGS)) u_reg_file (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_req_wr     (reg_req_wr),
    .i_req_rd     (reg_req_rd),
    .i_req_addr   (reg_req_addr),
    .i_req_data   (reg_req_data),
    .i_req_byte_en(reg_req_byte_en),
    .o_resp_ack   (reg_resp_ack),
    .o_resp_status(reg_resp_status),
    .o_resp_data  (reg_resp_data)
  );

endmodule

// ==== rtl/ctrlport_reg_file.sv ====
`timescale 1ns/100ps

module ctrlport_reg_file #(
  parameter int NUM_REGS = 8
) (
  input  logic                                 clk,
  input  logic                                 i_arst_n,
  input  logic                                 i_req_wr,
  input  logic                                 i_req_rd,
  input  logic [ctrlport_pkg::CTRL_ADDR_W-1:0] i_req_addr,
  input  logic [ctrlport_pkg::CTRL_DATA_W-1:0] i_req_data,
  input  logic [ctrlport_pkg::CTRL_BE_W-1:0]   i_req_byte_en,
  output logic                                 o_resp_ack,
  output ctrlport_pkg::ctrl_status_e           o_resp_status,
  output logic [ctrlport_pkg::CTRL_DATA_W-1:0] o_resp_data
);
  import ctrlport_pkg::*;

  // Register index width, at least one bit
  localparam int IDX_W = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

  logic [CTRL_DATA_W-1:0] regs [NUM_REGS];
  logic [CTRL_ADDR_W-3:0] word_addr;
  logic [IDX_W-1:0]       reg_idx;
  logic                   addr_hit;

  // Byte address to word index
  assign word_addr = i_req_addr[CTRL_ADDR_W-1:2];
  assign reg_idx   = word_addr[IDX_W-1:0];

  // Mapped only when word-aligned and inside the bank
  assign addr_hit = (i_req_addr[1:0] == 2'b00) && (int'(word_addr) < NUM_REGS);

  // Register bank with per-byte write enables
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_req_wr && addr_hit) begin
      for (int b = 0; b < CTRL_BE_W; b++) begin
        if (i_req_byte_en[b]) begin
          regs[reg_idx][8*b +: 8] <= i_req_data[8*b +: 8];
        end
      end
    end
  end

  // Ack one cycle after any request
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_resp_ack <= 1'b0;
    end else begin
      o_resp_ack <= i_req_wr || i_req_rd;
    end
  end

  // Status and read data travel with the ack
  // Writes and unmapped accesses return zero data
  always_ff @(posedge clk) begin
    if (i_req_wr || i_req_rd) begin
      o_resp_status <= addr_hit ? STS_OKAY : STS_CMDERR;
      o_resp_data   <= (addr_hit && i_req_rd) ? regs[reg_idx] : '0;
    end
  end

  // A request is either a read or a write
  a_wr_rd_exclusive : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    !(i_req_wr && i_req_rd)
  ) else $error("register file got read and write together");

endmodule

// ==== rtl/ctrlport_timer.sv ====
`timescale 1ns/100ps

module ctrlport_timer #(
  parameter bit EXEC_LATE_CMDS = 1'b0
) (
  input  logic                                 clk,
  input  logic                                 i_arst_n,
  input  logic [ctrlport_pkg::TIME_W-1:0]      i_time_now,
  input  logic                                 i_time_stb,
  input  logic [3:0]                           i_time_ignore_bits,
  input  logic                                 s_req_wr,
  input  logic                                 s_req_rd,
  input  logic [ctrlport_pkg::CTRL_ADDR_W-1:0] s_req_addr,
  input  logic [ctrlport_pkg::CTRL_DATA_W-1:0] s_req_data,
  input  logic [ctrlport_pkg::CTRL_BE_W-1:0]   s_req_byte_en,
  input  logic                                 s_req_has_time,
  input  logic [ctrlport_pkg::TIME_W-1:0]      s_req_time,
  output logic                                 s_resp_ack,
  output ctrlport_pkg::ctrl_status_e           s_resp_status,
  output logic [ctrlport_pkg::CTRL_DATA_W-1:0] s_resp_data,
  output logic                                 m_req_wr,
  output logic                                 m_req_rd,
  output logic [ctrlport_pkg::CTRL_ADDR_W-1:0] m_req_addr,
  output logic [ctrlport_pkg::CTRL_DATA_W-1:0] m_req_data,
  output logic [ctrlport_pkg::CTRL_BE_W-1:0]   m_req_byte_en,
  input  logic                                 m_resp_ack,
  input  ctrlport_pkg::ctrl_status_e           m_resp_status,
  input  logic [ctrlport_pkg::CTRL_DATA_W-1:0] m_resp_data
);
  import ctrlport_pkg::*;

  // Cached request: wr, rd, addr, data, byte enables, has_time, time
  localparam int REQ_W  = 2 + CTRL_ADDR_W + CTRL_DATA_W + CTRL_BE_W + 1 + TIME_W;
  // Cached response: status and data
  localparam int RESP_W = 2 + CTRL_DATA_W;

  logic                   req_valid;
  logic                   req_has_time;
  logic [TIME_W-1:0]      req_time;
  logic [TIME_W-1:0]      time_mask;
  logic                   m_req_wr_raw;
  logic                   m_req_rd_raw;

  // Stage 0 masks both times
  logic                   valid_0;
  logic                   has_time_0;
  logic                   stb_0;
  logic [TIME_W-1:0]      now_0;
  logic [TIME_W-1:0]      req_time_0;
  // Stage 1 compares
  logic                   valid_1;
  logic                   has_time_1;
  logic                   stb_1;
  logic                   eq_1;
  logic                   lt_1;
  // Stage 2 decides
  logic                   pending;
  logic                   has_time_2;
  logic                   on_time;
  logic                   late;

  logic                   exec;
  logic                   drop;
  logic                   consume;
  ctrl_status_e           resp_status_in;
  logic [CTRL_DATA_W-1:0] resp_data_in;
  logic [1:0]             resp_status_q;

  // Holds the request until it is executed or dropped
  ctrlport_flop_fifo #(.WIDTH(REQ_W)) u_req_cache (
    .clk     (clk),
    .i_arst_n(i_arst_n),
    .i_data  ({s_req_wr, s_req_rd, s_req_addr, s_req_data, s_req_byte_en,
               s_req_has_time, s_req_time}),
    .i_valid (s_req_wr | s_req_rd),
    .i_ready (consume),
    .o_data  ({m_req_wr_raw, m_req_rd_raw, m_req_addr, m_req_data, m_req_byte_en,
               req_has_time, req_time}),
    .o_valid (req_valid)
  );

  // Ignore the low time bits in both operands
  assign time_mask = {TIME_W{1'b1}} << i_time_ignore_bits;

  // Pipeline valids and decision flags
  // Cleared on consume so a popped request leaves no trace behind
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      valid_0 <= 1'b0;
      valid_1 <= 1'b0;
      pending <= 1'b0;
      on_time <= 1'b0;
      late    <= 1'b0;
    end else if (consume) begin
      valid_0 <= 1'b0;
      valid_1 <= 1'b0;
      pending <= 1'b0;
      on_time <= 1'b0;
      late    <= 1'b0;
    end else begin
      valid_0 <= req_valid;
      valid_1 <= valid_0;
      pending <= valid_1;
      // Time is only trusted in the cycle it was strobed
      on_time <= valid_1 && has_time_1 && stb_1 && eq_1;
      late    <= valid_1 && has_time_1 && stb_1 && lt_1;
    end
  end

  // Pipeline payload, qualified by the valids above
  always_ff @(posedge clk) begin
    has_time_0 <= req_has_time;
    stb_0      <= i_time_stb;
    now_0      <= i_time_now & time_mask;
    req_time_0 <= req_time & time_mask;
    has_time_1 <= has_time_0;
    stb_1      <= stb_0;
    eq_1       <= (req_time_0 == now_0);
    lt_1       <= (req_time_0 < now_0);
    has_time_2 <= has_time_1;
  end

  // Untimed goes straight through, timed waits for its tick
  assign exec    = pending && (!has_time_2 || on_time || (EXEC_LATE_CMDS && late));
  assign drop    = late && !exec;
  assign consume = exec || drop;

  assign m_req_wr = m_req_wr_raw & exec;
  assign m_req_rd = m_req_rd_raw & exec;

  // Dropped requests answer locally with a timestamp error
  assign resp_status_in = drop ? STS_TSERR : m_resp_status;
  assign resp_data_in   = drop ? '0 : m_resp_data;

  // Response is held one cycle and self-drains as the ack pulse
  ctrlport_flop_fifo #(.WIDTH(RESP_W)) u_resp_cache (
    .clk     (clk),
    .i_arst_n(i_arst_n),
    .i_data  ({resp_status_in, resp_data_in}),
    .i_valid (m_resp_ack | drop),
    .i_ready (s_resp_ack),
    .o_data  ({resp_status_q, s_resp_data}),
    .o_valid (s_resp_ack)
  );

  assign s_resp_status = ctrl_status_e'(resp_status_q);

  // Downstream strobes only for a cached request chosen for execution
  a_fwd_needs_exec : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    (m_req_wr || m_req_rd) |-> (exec && req_valid)
  ) else $error("downstream request without execute");

  // Host keeps one request outstanding
  a_one_outstanding : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    (s_req_wr || s_req_rd) |-> !req_valid
  ) else $error("new request while previous one is still cached");

endmodule

// ==== rtl/timebase_counter.sv ====
`timescale 1ns/100ps

module timebase_counter #(
  parameter int TICK_DIV = 4
) (
  input  logic                            clk,
  input  logic                            i_arst_n,
  output logic [ctrlport_pkg::TIME_W-1:0] o_time_now,
  output logic                            o_time_stb
);
  import ctrlport_pkg::*;

  // Divider sized for the strobe period, at least one bit
  localparam int               DIV_W    = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(TICK_DIV - 1);

  logic [DIV_W-1:0] div_cnt;
  logic             div_wrap;

  // Last cycle of the divider period
  assign div_wrap = (div_cnt == DIV_LAST);

  // Strobe and time update on the same edge
  // so the new time is valid together with the strobe
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      div_cnt    <= '0;
      o_time_stb <= 1'b0;
      o_time_now <= '0;
    end else begin
      o_time_stb <= div_wrap;
      if (div_wrap) begin
        div_cnt    <= '0;
        o_time_now <= o_time_now + TIME_W'(1);
      end else begin
        div_cnt <= div_cnt + DIV_W'(1);
      end
    end
  end

endmodule

// ==== rtl/ctrlport_flop_fifo.sv ====
`timescale 1ns/100ps

module ctrlport_flop_fifo #(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             i_arst_n,
  input  logic [WIDTH-1:0] i_data,
  input  logic             i_valid,
  input  logic             i_ready,
  output logic [WIDTH-1:0] o_data,
  output logic             o_valid
);

  // Single storage slot
  logic [WIDTH-1:0] data_q;
  logic             full;

  // Occupancy flag
  // A push wins over a pop in the same cycle, so push-while-popping refills
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      full <= 1'b0;
    end else if (i_valid) begin
      full <= 1'b1;
    end else if (i_ready && full) begin
      full <= 1'b0;
    end
  end

  // Payload capture on every push
  always_ff @(posedge clk) begin
    if (i_valid) begin
      data_q <= i_data;
    end
  end

  assign o_data  = data_q;
  assign o_valid = full;

  // Overflow check: the slot may only be overwritten while it is being drained
  a_no_overflow : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    (i_valid && full) |-> i_ready
  ) else $error("flop fifo pushed while full without a pop");

endmodule

// ==== rtl/ctrlport_pkg.sv ====
package ctrlport_pkg;

  // Control-port request address width
  // Byte addresses; registers sit on 32-bit word boundaries
  localparam int CTRL_ADDR_W = 20;

  // Request and response data width
  localparam int CTRL_DATA_W = 32;

  // One byte enable per data byte
  localparam int CTRL_BE_W = CTRL_DATA_W / 8;

  // Timestamp width for timed requests and the local timebase
  localparam int TIME_W = 64;

  // Response status carried with every acknowledge
  // Encoding matches the control-port status field
  typedef enum logic [1:0] {
    // Request completed
    STS_OKAY    = 2'b00,
    // Address not mapped in the endpoint
    STS_CMDERR  = 2'b01,
    // Timed request arrived late and was dropped
    STS_TSERR   = 2'b10,
    // Reserved for endpoint warnings, not generated here
    STS_WARNING = 2'b11
  } ctrl_status_e;

endpackage
